/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = decode_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
source/decode_pkg.sv
source/prefix_decode.sv
source/opcode_decode.sv
source/modrm_decode.sv
source/operand_extract.sv
source/eip_unit.sv
source/decode_top.sv
testbench/decode_tb.sv

/* source/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    //////////////////////////////////////////////////
    // basic field types
    //////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;     // one packet byte
    typedef logic [31:0] eip_t;      // instruction pointer, also disp/imm width
    typedef logic [2:0]  reg_idx_t;  // gpr or segment number
    typedef logic [4:0]  len_t;      // instr length, max 14

    // decoded operation class
    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_MOV     = 3'd1,
        OP_JMP     = 3'd2,
        OP_NOP     = 3'd3,
        OP_ILLEGAL = 3'd4
    } op_kind_e;

    // supported primary opcode bytes
    typedef enum logic [7:0] {
        ADD_RM_R       = 8'h01,  // add r/m32, r32
        ADD_R_RM       = 8'h03,  // add r32, r/m32
        ADD_EAX_IMM    = 8'h05,  // add eax, imm32
        MOV_RM_R       = 8'h89,  // mov r/m32, r32
        MOV_R_RM       = 8'h8B,  // mov r32, r/m32
        NOP_BYTE       = 8'h90,
        MOV_R_IMM_BASE = 8'hB8,  // b8+r, low 3 bits pick the register
        JMP_REL32      = 8'hE9,
        JMP_REL8       = 8'hEB
    } opcode_e;

    // segment register numbering, x86 sreg order
    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } seg_e;

    //////////////////////////////////////////////////
    // legacy prefix bytes
    //////////////////////////////////////////////////

    localparam byte_t PFX_REP    = 8'hF3;
    localparam byte_t PFX_OPSIZE = 8'h66;
    localparam byte_t PFX_ES     = 8'h26;
    localparam byte_t PFX_CS     = 8'h2E;
    localparam byte_t PFX_SS     = 8'h36;
    localparam byte_t PFX_DS     = 8'h3E;
    localparam byte_t PFX_FS     = 8'h64;
    localparam byte_t PFX_GS     = 8'h65;

    localparam int MAX_PREFIXES = 3;  // only the first three bytes are scanned

endpackage

`default_nettype wire

/* source/decode_top.sv */
`default_nettype none

module decode_top import decode_pkg::*; #(
    parameter int PACKET_BYTES = 16
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      valid_in,
    input  wire [PACKET_BYTES*8-1:0] packet_in,
    input  wire                      queue_full_stall,
    input  wire                      is_init,
    input  wire eip_t                init_eip,
    input  wire                      is_resteer,
    input  wire eip_t                wb_eip,
    input  wire                      bp_taken,
    input  wire eip_t                bp_eip,
    output logic                     valid_out,
    output op_kind_e                 op_kind,
    output logic                     illegal,
    output reg_idx_t                 reg_dst,
    output reg_idx_t                 reg_src,
    output reg_idx_t                 base_reg,
    output reg_idx_t                 index_reg,
    output logic                     use_base,
    output logic                     use_index,
    output logic [1:0]               scale,
    output eip_t                     disp,
    output eip_t                     imm,
    output logic                     opsize_16,
    output logic                     rep,
    output seg_e                     seg_sel,
    output logic                     seg_override,
    output len_t                     length,
    output eip_t                     latched_eip,
    output eip_t                     eip_out
);

    byte_t      lead [6];  // bytes 0..5, enough for opcode/modrm/sib
    logic [1:0] num_prefixes;
    seg_e       seg_sel_pfx;
    byte_t      opc, modrm, sib;
    logic       has_modrm, modrm_is_dst, imm_signed, uses_implied_reg;
    logic [2:0] imm_size, disp_size, modrm_len;
    reg_idx_t   implied_reg;

    for (genvar g = 0; g < 6; g++) begin : g_lead
        assign lead[g] = packet_in[PACKET_BYTES*8-1-8*g -: 8];
    end

    // opcode follows the prefixes
    assign opc   = lead[3'(num_prefixes)];
    assign modrm = lead[3'(num_prefixes) + 3'd1];
    assign sib   = lead[3'(num_prefixes) + 3'd2];

    prefix_decode u_prefix (
        .byte0(lead[0]), .byte1(lead[1]), .byte2(lead[2]),
        .num_prefixes(num_prefixes), .rep(rep), .opsize_16(opsize_16),
        .seg_override(seg_override), .seg_sel_pfx(seg_sel_pfx)
    );

    opcode_decode u_opcode (
        .opc(opc), .opsize_16(opsize_16), .op_kind(op_kind), .has_modrm(has_modrm),
        .modrm_is_dst(modrm_is_dst), .imm_size(imm_size), .imm_signed(imm_signed),
        .implied_reg(implied_reg), .uses_implied_reg(uses_implied_reg), .illegal(illegal)
    );

    modrm_decode u_modrm (
        .modrm(modrm), .sib(sib), .has_modrm(has_modrm), .modrm_is_dst(modrm_is_dst),
        .implied_reg(implied_reg), .uses_implied_reg(uses_implied_reg),
        .seg_override(seg_override), .seg_sel_pfx(seg_sel_pfx),
        .reg_field(), .rm_reg(), .base_reg(base_reg), .index_reg(index_reg),
        .reg_form(), .use_base(use_base), .use_index(use_index), .scale(scale),
        .disp_size(disp_size), .modrm_len(modrm_len),
        .reg_dst(reg_dst), .reg_src(reg_src), .seg_sel(seg_sel)
    );

    operand_extract #(.PACKET_BYTES(PACKET_BYTES)) u_operand (
        .packet(packet_in), .num_prefixes(num_prefixes), .has_modrm(has_modrm),
        .modrm_len(modrm_len), .disp_size(disp_size), .imm_size(imm_size),
        .imm_signed(imm_signed), .disp(disp), .imm(imm), .length(length)
    );

    eip_unit u_eip (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .queue_full_stall(queue_full_stall),
        .length(length), .is_init(is_init), .init_eip(init_eip),
        .is_resteer(is_resteer), .wb_eip(wb_eip), .bp_taken(bp_taken), .bp_eip(bp_eip),
        .valid_out(valid_out), .latched_eip(latched_eip), .eip_out(eip_out)
    );

endmodule

`default_nettype wire

/* source/eip_unit.sv */
`default_nettype none

module eip_unit import decode_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        valid_in,
    input  wire        queue_full_stall,
    input  wire len_t  length,
    input  wire        is_init,
    input  wire eip_t  init_eip,
    input  wire        is_resteer,
    input  wire eip_t  wb_eip,
    input  wire        bp_taken,
    input  wire eip_t  bp_eip,
    output logic       valid_out,
    output eip_t       latched_eip,
    output eip_t       eip_out
);

    len_t adv_len;  // length only when a packet is present

    assign valid_out = valid_in && !queue_full_stall;  // stall kills the strobe
    assign adv_len   = valid_in ? length : '0;
    assign eip_out   = latched_eip + eip_t'(adv_len);

    //////////////////////////////////////////////////
    // eip register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            latched_eip <= '0;
        end else if (is_init) begin
            latched_eip <= init_eip;   // highest priority
        end else if (is_resteer) begin
            latched_eip <= wb_eip;     // writeback redirect
        end else if (bp_taken) begin
            latched_eip <= bp_eip;     // predicted taken
        end else if (valid_out) begin
            latched_eip <= eip_out;    // sequential on accept
        end
    end

endmodule

`default_nettype wire

/* source/modrm_decode.sv */
`default_nettype none

module modrm_decode import decode_pkg::*; (
    input  wire byte_t     modrm,
    input  wire byte_t     sib,
    input  wire            has_modrm,
    input  wire            modrm_is_dst,
    input  wire reg_idx_t  implied_reg,
    input  wire            uses_implied_reg,
    input  wire            seg_override,
    input  wire seg_e      seg_sel_pfx,
    output reg_idx_t       reg_field,
    output reg_idx_t       rm_reg,
    output reg_idx_t       base_reg,
    output reg_idx_t       index_reg,
    output logic           reg_form,
    output logic           use_base,
    output logic           use_index,
    output logic [1:0]     scale,
    output logic [2:0]     disp_size,
    output logic [2:0]     modrm_len,   // modrm + sib + disp bytes
    output reg_idx_t       reg_dst,
    output reg_idx_t       reg_src,
    output seg_e           seg_sel
);

    logic [1:0] mod_f;
    logic       has_sib;

    assign mod_f     = modrm[7:6];
    assign reg_field = modrm[5:3];
    assign rm_reg    = modrm[2:0];
    assign reg_form  = has_modrm && mod_f == 2'b11;
    assign has_sib   = has_modrm && !reg_form && rm_reg == 3'b100;

    //////////////////////////////////////////////////
    // 32-bit addressing table
    //////////////////////////////////////////////////

    always_comb begin
        base_reg  = has_sib ? sib[2:0] : rm_reg;
        index_reg = sib[5:3];
        scale     = has_sib ? sib[7:6] : 2'b00;
        use_index = has_sib && sib[5:3] != 3'b100;  // index 100 = none
        use_base  = has_modrm && !reg_form;
        case (mod_f)
            2'b01:   disp_size = 3'd1;
            2'b10:   disp_size = 3'd4;
            default: disp_size = 3'd0;
        endcase
        if (use_base && mod_f == 2'b00 && base_reg == 3'b101) begin
            use_base  = 1'b0;  // disp32, no base
            disp_size = 3'd4;
        end
        if (!use_base && !(has_modrm && !reg_form)) disp_size = 3'd0;
        if (has_modrm) modrm_len = 3'd1 + {2'b00, has_sib} + disp_size;
        else           modrm_len = 3'd0;
    end

    // register roles
    always_comb begin
        if (has_modrm) begin
            reg_dst = modrm_is_dst ? rm_reg : reg_field;
            reg_src = modrm_is_dst ? reg_field : rm_reg;
        end else begin
            reg_dst = uses_implied_reg ? implied_reg : '0;
            reg_src = '0;
        end
    end

    // ss default for esp/ebp base (100, 101)
    assign seg_sel = seg_override ? seg_sel_pfx :
                     (use_base && base_reg[2:1] == 2'b10) ? SS : DS;

endmodule

`default_nettype wire

/* source/opcode_decode.sv */
`default_nettype none

module opcode_decode import decode_pkg::*; (
    input  wire byte_t  opc,
    input  wire         opsize_16,
    output op_kind_e    op_kind,
    output logic        has_modrm,
    output logic        modrm_is_dst,      // r/m operand is written
    output logic [2:0]  imm_size,          // bytes, 0/1/2/4
    output logic        imm_signed,
    output reg_idx_t    implied_reg,
    output logic        uses_implied_reg,
    output logic        illegal
);

    logic [2:0] wide_imm;  // imm32, or imm16 under 66

    assign wide_imm = opsize_16 ? 3'd2 : 3'd4;

    //////////////////////////////////////////////////
    // opcode table
    //////////////////////////////////////////////////

    always_comb begin
        op_kind          = OP_ILLEGAL;
        has_modrm        = 1'b0;
        modrm_is_dst     = 1'b0;
        imm_size         = 3'd0;
        imm_signed       = 1'b0;
        implied_reg      = '0;
        uses_implied_reg = 1'b0;
        illegal          = 1'b0;

        if ((opc & 8'hF8) == MOV_R_IMM_BASE) begin
            // b8..bf mov r32, imm
            op_kind          = OP_MOV;
            imm_size         = wide_imm;
            implied_reg      = opc[2:0];
            uses_implied_reg = 1'b1;
        end else begin
            case (opc)
                ADD_RM_R, MOV_RM_R: begin
                    op_kind      = (opc == ADD_RM_R) ? OP_ADD : OP_MOV;
                    has_modrm    = 1'b1;
                    modrm_is_dst = 1'b1;  // reg -> r/m
                end
                ADD_R_RM, MOV_R_RM: begin
                    op_kind   = (opc == ADD_R_RM) ? OP_ADD : OP_MOV;
                    has_modrm = 1'b1;     // r/m -> reg
                end
                ADD_EAX_IMM: begin
                    op_kind          = OP_ADD;
                    imm_size         = wide_imm;
                    uses_implied_reg = 1'b1;  // eax is reg 0
                end
                JMP_REL8: begin
                    op_kind    = OP_JMP;
                    imm_size   = 3'd1;
                    imm_signed = 1'b1;    // rel8 sign extends
                end
                JMP_REL32: begin
                    op_kind  = OP_JMP;
                    imm_size = wide_imm;
                end
                NOP_BYTE: op_kind = OP_NOP;
                default: illegal = 1'b1;  // length falls back to 1
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/operand_extract.sv */
`default_nettype none

module operand_extract import decode_pkg::*; #(
    parameter int PACKET_BYTES = 16
) (
    input  wire [PACKET_BYTES*8-1:0] packet,     // byte 0 in top bits
    input  wire [1:0]                num_prefixes,
    input  wire                      has_modrm,
    input  wire [2:0]                modrm_len,
    input  wire [2:0]                disp_size,
    input  wire [2:0]                imm_size,
    input  wire                      imm_signed,
    output eip_t                     disp,
    output eip_t                     imm,
    output len_t                     length
);

    byte_t      pkt_byte [PACKET_BYTES];
    logic [3:0] imm_off;   // first imm byte
    logic [3:0] disp_off;  // first disp byte, trails modrm/sib
    eip_t       disp_raw;
    eip_t       imm_raw;

    for (genvar g = 0; g < PACKET_BYTES; g++) begin : g_bytes
        assign pkt_byte[g] = packet[(PACKET_BYTES-1-g)*8 +: 8];
    end

    assign imm_off  = 4'(num_prefixes) + 4'd1 + 4'(modrm_len);
    assign disp_off = imm_off - 4'(disp_size);

    //////////////////////////////////////////////////
    // little-endian assembly
    //////////////////////////////////////////////////

    always_comb begin
        disp_raw = '0;
        imm_raw  = '0;
        for (int k = 0; k < 4; k++) begin
            if (k < disp_size) disp_raw[k*8 +: 8] = pkt_byte[disp_off + k];
            if (k < imm_size)  imm_raw[k*8 +: 8]  = pkt_byte[imm_off + k];
        end
    end

    always_comb begin
        if (!has_modrm)          disp = '0;
        else if (disp_size == 1) disp = {{24{disp_raw[7]}}, disp_raw[7:0]};  // disp8
        else                     disp = disp_raw;
        case (imm_size)
            3'd1:    imm = imm_signed ? {{24{imm_raw[7]}}, imm_raw[7:0]} : imm_raw;
            3'd2:    imm = imm_signed ? {{16{imm_raw[15]}}, imm_raw[15:0]} : imm_raw;
            default: imm = imm_raw;  // imm32 or none
        endcase
    end

    // prefixes + opcode + modrm/sib/disp + imm
    assign length = len_t'(imm_off) + len_t'(imm_size);

endmodule

`default_nettype wire

/* source/prefix_decode.sv */
`default_nettype none

module prefix_decode import decode_pkg::*; (
    input  wire byte_t  byte0,
    input  wire byte_t  byte1,
    input  wire byte_t  byte2,
    output logic [1:0]  num_prefixes,
    output logic        rep,
    output logic        opsize_16,
    output logic        seg_override,
    output seg_e        seg_sel_pfx
);

    byte_t lead [MAX_PREFIXES];  // leading packet bytes
    logic  stop;                 // first non-prefix seen

    // segment override byte to segment number
    function automatic seg_e pfx_seg(input byte_t b);
        case (b)
            PFX_ES:  pfx_seg = ES;
            PFX_CS:  pfx_seg = CS;
            PFX_SS:  pfx_seg = SS;
            PFX_FS:  pfx_seg = FS;
            PFX_GS:  pfx_seg = GS;
            default: pfx_seg = DS;
        endcase
    endfunction

    assign lead[0] = byte0;
    assign lead[1] = byte1;
    assign lead[2] = byte2;

    always_comb begin
        num_prefixes = 2'd0;
        rep          = 1'b0;
        opsize_16    = 1'b0;
        seg_override = 1'b0;
        seg_sel_pfx  = DS;  // don't care unless seg_override
        stop         = 1'b0;
        for (int i = 0; i < MAX_PREFIXES; i++) begin
            if (!stop) begin
                if (lead[i] == PFX_REP) begin
                    rep = 1'b1;
                end else if (lead[i] == PFX_OPSIZE) begin
                    opsize_16 = 1'b1;
                end else if (lead[i] inside {PFX_ES, PFX_CS, PFX_SS, PFX_DS, PFX_FS, PFX_GS}) begin
                    seg_override = 1'b1;
                    seg_sel_pfx  = pfx_seg(lead[i]);  // later override wins
                end else begin
                    stop = 1'b1;  // opcode reached
                end
                if (!stop) num_prefixes = num_prefixes + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/decode_tb.sv */
`default_nettype none

module decode_tb import decode_pkg::*; ();

    localparam int PKT_BYTES  = 16;
    localparam int CLK_PERIOD = 20;

    // cycles per test summed for the watchdog
    localparam int RESET_CYCLES = 3;
    localparam int REG_CYCLES   = 8;
    localparam int MEM_CYCLES   = 6;
    localparam int PFX_CYCLES   = 11;
    localparam int IMM_CYCLES   = 16;
    localparam int EIP_CYCLES   = 10;
    localparam int RUN_CYCLES   = RESET_CYCLES + REG_CYCLES + MEM_CYCLES
                                + PFX_CYCLES + IMM_CYCLES + EIP_CYCLES;
    localparam int MARGIN_TIME  = 20 * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n;
    logic                   valid_in;
    logic                   queue_full_stall;
    logic [PKT_BYTES*8-1:0] packet_in;
    logic                   is_init;
    logic                   is_resteer;
    logic                   bp_taken;
    eip_t                   init_eip;
    eip_t                   wb_eip;
    eip_t                   bp_eip;

    logic       valid_out;
    logic       illegal;
    logic       use_base;
    logic       use_index;
    logic       opsize_16;
    logic       rep;
    logic       seg_override;
    op_kind_e   op_kind;
    reg_idx_t   reg_dst;
    reg_idx_t   reg_src;
    reg_idx_t   base_reg;
    reg_idx_t   index_reg;
    logic [1:0] scale;
    eip_t       disp;
    eip_t       imm;
    eip_t       latched_eip;
    eip_t       eip_out;
    seg_e       seg_sel;
    len_t       length;

    byte_t       pb [PKT_BYTES];  // packet under construction with byte 0 first
    logic [31:0] rng;             // xorshift state
    string       test_name;
    eip_t        exp_eip;         // model of latched_eip

    decode_top #(.PACKET_BYTES(PKT_BYTES)) uut (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .packet_in(packet_in),
        .queue_full_stall(queue_full_stall), .is_init(is_init), .init_eip(init_eip),
        .is_resteer(is_resteer), .wb_eip(wb_eip), .bp_taken(bp_taken), .bp_eip(bp_eip),
        .valid_out(valid_out), .op_kind(op_kind), .illegal(illegal),
        .reg_dst(reg_dst), .reg_src(reg_src), .base_reg(base_reg), .index_reg(index_reg),
        .use_base(use_base), .use_index(use_index), .scale(scale),
        .disp(disp), .imm(imm), .opsize_16(opsize_16), .rep(rep),
        .seg_sel(seg_sel), .seg_override(seg_override), .length(length),
        .latched_eip(latched_eip), .eip_out(eip_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD + MARGIN_TIME);
        $display("watchdog expired, the tests did not finish in time");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    function automatic eip_t sext8(input byte_t b);
        return {{24{b[7]}}, b};  // disp8 / rel8 rule
    endfunction

    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < PKT_BYTES; i++) begin
            next_rand(r);
            pb[i] = r[7:0];  // tail bytes must not matter
        end
    endtask

    task automatic put_le32(input int pos, input eip_t val);
        for (int k = 0; k < 4; k++) pb[pos + k] = val[k*8 +: 8];  // little endian
    endtask

    // drive on the falling edge and sample a quarter period later
    task automatic drive_cycle(input logic v, input logic stall,
                               input logic init, input eip_t ie,
                               input logic rs, input eip_t we,
                               input logic bp, input eip_t be);
        @(negedge clk);
        valid_in         = v;
        queue_full_stall = stall;
        is_init          = init;
        init_eip         = ie;
        is_resteer       = rs;
        wb_eip           = we;
        bp_taken         = bp;
        bp_eip           = be;
        for (int i = 0; i < PKT_BYTES; i++) packet_in[(PKT_BYTES-1-i)*8 +: 8] = pb[i];
        #(CLK_PERIOD/4);
    endtask

    task automatic drive_packet(input logic v, input logic stall);
        drive_cycle(v, stall, 1'b0, '0, 1'b0, '0, 1'b0, '0);  // no redirect
    endtask

    task automatic check_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", test_name, field, exp, act);
            $display("Regression failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // address fields with index and base checked only when used
    task automatic check_addressing(input logic ub, input reg_idx_t b, input logic ui,
                                    input reg_idx_t ix, input logic [1:0] sc,
                                    input eip_t d, input len_t len, input seg_e sg);
        check_value("use_base", ub, use_base);
        if (ub) check_value("base_reg", b, base_reg);
        check_value("use_index", ui, use_index);
        if (ui) check_value("index_reg", ix, index_reg);
        check_value("scale", sc, scale);
        check_value("disp", d, disp);
        check_value("length", len, length);
        check_value("seg_sel", sg, seg_sel);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic register_forms();
        byte_t       ops [4];
        byte_t       opc;
        logic [31:0] r;
        reg_idx_t    rg;
        reg_idx_t    rm;
        logic        rm_dst;
        test_name = "reg_forms";
        ops = '{8'h01, 8'h03, 8'h89, 8'h8B};
        for (int n = 0; n < 8; n++) begin
            next_rand(r);
            opc    = ops[n % 4];
            rg     = r[2:0];
            rm     = r[5:3];
            rm_dst = (opc == 8'h01) || (opc == 8'h89);  // r/m is written
            fill_random();
            pb[0] = opc;
            pb[1] = {2'b11, rg, rm};  // mod 11
            drive_packet(1'b1, 1'b0);
            check_value("op_kind", (opc inside {8'h01, 8'h03}) ? OP_ADD : OP_MOV, op_kind);
            check_value("reg_dst", rm_dst ? rm : rg, reg_dst);
            check_value("reg_src", rm_dst ? rg : rm, reg_src);
            check_value("use_base", 0, use_base);
            check_value("length", 2, length);
        end
    endtask

    task automatic memory_forms();
        logic [31:0] r;
        eip_t        d32;
        byte_t       d8;
        reg_idx_t    rg;
        reg_idx_t    b;
        reg_idx_t    ix;
        logic [1:0]  sc;
        test_name = "mem_forms";
        next_rand(r);
        next_rand(d32);
        rg = r[2:0];
        d8 = r[15:8] | 8'h80;  // force negative
        b  = r[18:16];
        ix = (r[21:19] == 3'b100) ? 3'b001 : r[21:19];
        sc = r[23:22];
        fill_random();  // [ebx + disp8]
        pb[0] = 8'h8B;
        pb[1] = {2'b01, rg, 3'b011};
        pb[2] = d8;
        drive_packet(1'b1, 1'b0);
        check_value("reg_dst", rg, reg_dst);
        check_addressing(1'b1, 3'd3, 1'b0, 3'd0, 2'd0, sext8(d8), 5'd3, DS);
        fill_random();  // [ebp + disp32] takes ss by default
        pb[1] = {2'b10, rg, 3'b101};
        pb[0] = 8'h8B;
        put_le32(2, d32);
        drive_packet(1'b1, 1'b0);
        check_addressing(1'b1, 3'd5, 1'b0, 3'd0, 2'd0, d32, 5'd6, SS);
        fill_random();  // full sib + disp8
        pb[0] = 8'h8B;
        pb[1] = {2'b01, rg, 3'b100};
        pb[2] = {sc, ix, b};
        pb[3] = d8;
        drive_packet(1'b1, 1'b0);
        check_addressing(1'b1, b, 1'b1, ix, sc, sext8(d8), 5'd4,
                         (b == 3'd4 || b == 3'd5) ? SS : DS);
        fill_random();  // [esp] where index 100 means none
        pb[0] = 8'h8B;
        pb[1] = {2'b00, rg, 3'b100};
        pb[2] = 8'b00_100_100;
        drive_packet(1'b1, 1'b0);
        check_addressing(1'b1, 3'd4, 1'b0, 3'd0, 2'd0, 32'h0, 5'd3, SS);
        fill_random();  // [disp32]
        pb[0] = 8'h8B;
        pb[1] = {2'b00, rg, 3'b101};
        put_le32(2, d32);
        drive_packet(1'b1, 1'b0);
        check_addressing(1'b0, 3'd0, 1'b0, 3'd0, 2'd0, d32, 5'd6, DS);
        fill_random();  // sib base 101 under mod 00
        pb[0] = 8'h8B;
        pb[1] = {2'b00, rg, 3'b100};
        pb[2] = 8'b10_001_101;
        put_le32(3, d32);
        drive_packet(1'b1, 1'b0);
        check_addressing(1'b0, 3'd0, 1'b1, 3'd1, 2'd2, d32, 5'd7, DS);
    endtask

    task automatic legacy_prefixes();
        byte_t       segs [6];
        logic [31:0] r;
        reg_idx_t    rg;
        test_name = "prefixes";
        segs = '{PFX_ES, PFX_CS, PFX_SS, PFX_DS, PFX_FS, PFX_GS};
        next_rand(r);
        rg = r[2:0];
        fill_random();  // rep nop
        pb[0] = 8'hF3;
        pb[1] = 8'h90;
        drive_packet(1'b1, 1'b0);
        check_value("rep", 1, rep);
        check_value("opsize_16", 0, opsize_16);
        check_value("op_kind", OP_NOP, op_kind);
        check_value("length", 2, length);
        fill_random();  // 66 b8+r imm16
        pb[0] = 8'h66;
        pb[1] = 8'hB8 | {5'd0, rg};
        pb[3] = pb[3] | 8'h80;  // high bit set but still zero extended
        drive_packet(1'b1, 1'b0);
        check_value("opsize_16", 1, opsize_16);
        check_value("reg_dst", rg, reg_dst);
        check_value("imm", {16'h0, pb[3], pb[2]}, imm);
        check_value("length", 4, length);
        fill_random();  // fs override beats the ss default
        pb[0] = 8'h64;
        pb[1] = 8'h8B;
        pb[2] = {2'b01, rg, 3'b101};
        drive_packet(1'b1, 1'b0);
        check_value("seg_override", 1, seg_override);
        check_addressing(1'b1, 3'd5, 1'b0, 3'd0, 2'd0, sext8(pb[3]), 5'd4, FS);
        fill_random();  // three stacked where the last segment wins
        pb[0] = 8'h26;
        pb[1] = 8'h66;
        pb[2] = 8'h65;
        pb[3] = 8'h89;
        pb[4] = {2'b00, rg, 3'b100};
        pb[5] = 8'b00_100_100;
        drive_packet(1'b1, 1'b0);
        check_value("rep", 0, rep);
        check_value("opsize_16", 1, opsize_16);
        check_value("op_kind", OP_MOV, op_kind);
        check_value("reg_src", rg, reg_src);
        check_addressing(1'b1, 3'd4, 1'b0, 3'd0, 2'd0, 32'h0, 5'd6, GS);
        fill_random();  // a fourth f3 is the opcode
        for (int i = 0; i < 4; i++) pb[i] = 8'hF3;
        drive_packet(1'b1, 1'b0);
        check_value("illegal", 1, illegal);
        check_value("length", 4, length);
        for (int s = 0; s < 6; s++) begin
            fill_random();
            pb[0] = segs[s];
            pb[1] = 8'h90;
            drive_packet(1'b1, 1'b0);
            check_value("seg_sel", s, seg_sel);  // es..gs numbered 0..5
            check_value("length", 2, length);
        end
    endtask

    task automatic immediates_and_branches();
        byte_t bad [4];
        eip_t  d32;
        test_name = "imm_branch";
        bad = '{8'h0F, 8'hC3, 8'hFF, 8'h8D};
        next_rand(d32);
        fill_random();  // add eax imm32
        pb[0] = 8'h05;
        put_le32(1, d32);
        drive_packet(1'b1, 1'b0);
        check_value("op_kind", OP_ADD, op_kind);
        check_value("reg_dst", 0, reg_dst);
        check_value("imm", d32, imm);
        check_value("length", 5, length);
        for (int n = 0; n < 8; n++) begin
            next_rand(d32);
            fill_random();
            pb[0] = 8'hB8 + 8'(n);
            put_le32(1, d32);
            drive_packet(1'b1, 1'b0);
            check_value("op_kind", OP_MOV, op_kind);
            check_value("reg_dst", n, reg_dst);
            check_value("imm", d32, imm);
            check_value("length", 5, length);
        end
        fill_random();  // jmp short back
        pb[0] = 8'hEB;
        pb[1] = pb[1] | 8'h80;
        drive_packet(1'b1, 1'b0);
        check_value("op_kind", OP_JMP, op_kind);
        check_value("imm", sext8(pb[1]), imm);
        check_value("length", 2, length);
        fill_random();
        pb[0] = 8'hE9;
        put_le32(1, d32);
        drive_packet(1'b1, 1'b0);
        check_value("op_kind", OP_JMP, op_kind);
        check_value("imm", d32, imm);
        check_value("length", 5, length);
        fill_random();
        pb[0] = 8'h90;
        drive_packet(1'b1, 1'b0);
        check_value("op_kind", OP_NOP, op_kind);
        check_value("illegal", 0, illegal);
        check_value("length", 1, length);
        for (int n = 0; n < 4; n++) begin
            fill_random();
            pb[0] = bad[n];
            drive_packet(1'b1, 1'b0);
            check_value("op_kind", OP_ILLEGAL, op_kind);
            check_value("illegal", 1, illegal);
            check_value("length", 1, length);
        end
    endtask

    task automatic eip_tracking();
        logic [31:0] r;
        eip_t        a;
        eip_t        b;
        eip_t        c;
        len_t        len;
        test_name = "eip";
        next_rand(exp_eip);
        fill_random();
        pb[0] = 8'h90;
        drive_cycle(1'b0, 1'b0, 1'b1, exp_eip, 1'b0, '0, 1'b0, '0);  // init load
        for (int n = 0; n < 3; n++) begin
            fill_random();
            case (n)
                0: begin
                    pb[0] = 8'h89;
                    pb[1] = 8'hC1;  // register form
                    len   = 5'd2;
                end
                1: begin
                    pb[0] = 8'hBA;  // mov edx imm32
                    len   = 5'd5;
                end
                default: begin
                    pb[0] = 8'h8B;
                    pb[1] = 8'h05;  // [disp32]
                    len   = 5'd6;
                end
            endcase
            drive_packet(1'b1, 1'b0);
            check_value("latched_eip", exp_eip, latched_eip);
            check_value("valid_out", 1, valid_out);
            check_value("eip_out", exp_eip + 32'(len), eip_out);
            exp_eip = exp_eip + 32'(len);  // accepted on this edge
        end
        drive_packet(1'b1, 1'b1);  // stalled with the last packet again
        check_value("valid_out", 0, valid_out);
        check_value("eip_out", exp_eip + 32'(len), eip_out);
        drive_packet(1'b0, 1'b0);
        check_value("latched_eip", exp_eip, latched_eip);  // held
        check_value("eip_out", exp_eip, eip_out);
        next_rand(a);
        next_rand(b);
        next_rand(c);
        drive_cycle(1'b1, 1'b1, 1'b0, '0, 1'b1, a, 1'b1, b);  // resteer over bp despite stall
        check_value("latched_eip", exp_eip, latched_eip);
        drive_cycle(1'b1, 1'b0, 1'b0, '0, 1'b0, '0, 1'b1, c);  // bp over the sequential advance
        check_value("latched_eip", a, latched_eip);
        next_rand(r);
        drive_cycle(1'b1, 1'b0, 1'b1, r, 1'b1, a, 1'b1, b);  // init first
        check_value("latched_eip", c, latched_eip);
        drive_packet(1'b0, 1'b0);
        check_value("latched_eip", r, latched_eip);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rng              = 32'h820c;
        rst_n            = 1'b0;
        valid_in         = 1'b0;
        queue_full_stall = 1'b0;
        packet_in        = '0;
        is_init          = 1'b0;
        is_resteer       = 1'b0;
        bp_taken         = 1'b0;
        init_eip         = '0;
        wb_eip           = '0;
        bp_eip           = '0;
        test_name        = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #(CLK_PERIOD/4);
        check_value("latched_eip", 0, latched_eip);
        check_value("valid_out", 0, valid_out);
        register_forms();
        memory_forms();
        legacy_prefixes();
        immediates_and_branches();
        eip_tracking();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
